//--- Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -f list.f --top-module tb_dcache -Mdir obj_dir
	./obj_dir/Vtb_dcache | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/tb_dcache.sv
`timescale 1ns/10ps
`include "cache_defs.svh"

module tb_dcache;

    localparam int ACK_TIMEOUT = 40; // a dirty miss takes well under this.

    logic              clk;
    logic              rst_b;
    logic              cyc;
    logic              stb;
    logic              we;
    bus_pkg::wb_addr_t adr;
    bus_pkg::wb_sel_t  sel;
    bus_pkg::wb_data_t dat_w;
    bus_pkg::wb_data_t dat_r;
    logic              ack;

    bus_pkg::wb_data_t ref_mem [`CACHE_MEM_WORDS];
    int unsigned       seed;

    dcache_top i_dcache_top (
        .clk(clk), .rst_b(rst_b), .cyc(cyc), .stb(stb), .we(we),
        .adr(adr), .sel(sel), .dat_w(dat_w), .dat_r(dat_r), .ack(ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int unsigned lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function automatic bus_pkg::wb_data_t lane_mask(input bus_pkg::wb_sel_t s);
        bus_pkg::wb_data_t m;
        for (int i = 0; i < $bits(bus_pkg::wb_sel_t); i++) begin
            m[8*i +: 8] = {8{s[i]}};
        end
        return m;
    endfunction

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_data(input string test_name, input bus_pkg::wb_data_t expected,
                              input bus_pkg::wb_data_t actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", test_name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_ack_low(input string test_name, input logic actual);
        if (actual !== 1'b0) begin
            $display("ERR %s expected %b actual %b", test_name, 1'b0, actual);
            abort_run();
        end
    endtask

    // called at a falling edge with the request already driven.
    task automatic wait_for_ack(input bus_pkg::wb_addr_t a, output bus_pkg::wb_data_t data);
        int   cycles;
        logic got;
        cycles = 0;
        got    = 1'b0;
        while (!got && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            got = ack;
        end
        if (!got) begin
            $display("the cache never acknowledged the access to address %h", a);
            abort_run();
        end
        data = dat_r;
        @(posedge clk); // the cache still sees the request on this edge.
        @(negedge clk);
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wb_write(input bus_pkg::wb_addr_t a, input bus_pkg::wb_sel_t s,
                            input bus_pkg::wb_data_t d);
        bus_pkg::wb_data_t unused;
        bus_pkg::wb_data_t m;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = a;
        sel   = s;
        dat_w = d;
        wait_for_ack(a, unused);
        m          = lane_mask(s);
        ref_mem[a] = (ref_mem[a] & ~m) | (d & m);
    endtask

    task automatic wb_read(input bus_pkg::wb_addr_t a, input bus_pkg::wb_sel_t s,
                           output bus_pkg::wb_data_t d);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b0;
        adr   = a;
        sel   = s;
        dat_w = '0;
        wait_for_ack(a, d);
    endtask

    task automatic read_and_check(input string test_name, input bus_pkg::wb_addr_t a,
                                  input bus_pkg::wb_sel_t s);
        bus_pkg::wb_data_t d;
        wb_read(a, s, d);
        check_data(test_name, ref_mem[a] & lane_mask(s), d); // unselected lanes read zero.
    endtask

    task automatic reset_state_test();
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            check_ack_low("reset_state", ack);
        end
        read_and_check("reset_state", 10'h123, 4'hf);
        read_and_check("reset_state", 10'h3ff, 4'hf);
    endtask

    task automatic word_access_test();
        wb_write(10'h001, 4'hf, 32'h1234_5678);
        wb_write(10'h002, 4'hf, 32'h9abc_def0);
        wb_write(10'h0f3, 4'hf, 32'h0bad_f00d);
        wb_write(10'h200, 4'hf, 32'hffff_0001);
        read_and_check("word_access", 10'h001, 4'hf);
        read_and_check("word_access", 10'h002, 4'hf);
        read_and_check("word_access", 10'h0f3, 4'hf);
        read_and_check("word_access", 10'h200, 4'hf);
    endtask

    task automatic byte_lane_test();
        wb_write(10'h045, 4'hf, 32'h0000_0000);
        wb_write(10'h045, 4'b0001, 32'hffff_ffa1); // upper lanes carry junk.
        wb_write(10'h045, 4'b0100, 32'h55c3_5555);
        wb_write(10'h045, 4'b1000, 32'h7e00_0000);
        read_and_check("byte_lanes", 10'h045, 4'hf);
        read_and_check("byte_lanes", 10'h045, 4'b0100);
        read_and_check("byte_lanes", 10'h045, 4'b0010);
        read_and_check("byte_lanes", 10'h045, 4'b0001);
    endtask

    task automatic dirty_eviction_test();
        wb_write(10'h017, 4'hf, 32'hdead_beef);
        wb_write(10'h027, 4'hf, 32'hcafe_f00d); // shares the index and evicts the first line.
        read_and_check("dirty_eviction", 10'h017, 4'hf);
        read_and_check("dirty_eviction", 10'h027, 4'hf);
    endtask

    task automatic random_traffic_test();
        int unsigned             r;
        int unsigned             pick;
        cache_pkg::cache_tag_t   tag_pick;
        cache_pkg::cache_index_t idx;
        bus_pkg::wb_sel_t        s;
        for (int n = 0; n < 200; n++) begin
            r    = lcg_next();
            pick = r % 3;
            case (pick)
                0: tag_pick = 6'h03;
                1: tag_pick = 6'h15;
                default: tag_pick = 6'h2a;
            endcase
            idx = r[11:8];
            s   = r[15:12];
            if (r[20]) begin
                wb_write({tag_pick, idx}, s, lcg_next());
            end else begin
                read_and_check("random_traffic", {tag_pick, idx}, s);
            end
        end
    endtask

    initial begin
        seed  = 97;
        rst_b = 1'b0;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        sel   = '0;
        dat_w = '0;
        for (int i = 0; i < `CACHE_MEM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_b = 1'b1;
        reset_state_test();
        word_access_test();
        byte_lane_test();
        dirty_eviction_test();
        random_traffic_test();
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- list.f
+incdir+rtl
rtl/bus_pkg.sv
rtl/cache_pkg.sv
rtl/mem_if.sv
rtl/cache_ram.sv
rtl/mem_latency_timer.sv
rtl/cache_ctrl.sv
rtl/cache_datapath.sv
rtl/main_mem.sv
rtl/dcache_top.sv
bench/tb_dcache.sv

//--- rtl/bus_pkg.sv
`include "cache_defs.svh"

package bus_pkg;

    typedef logic [`CACHE_ADDR_W-1:0] wb_addr_t; // Wishbone addresses count words.
    typedef logic [`CACHE_DATA_W-1:0] wb_data_t;
    typedef logic [`CACHE_SEL_W-1:0]  wb_sel_t;

endpackage

//--- rtl/cache_ctrl.sv
`timescale 1ns/10ps

module cache_ctrl (
    input  logic                   clk,
    input  logic                   rst_b,
    input  logic                   cyc,
    input  logic                   stb,
    input  logic                   we,
    input  logic                   hit,
    input  logic                   dirty,
    input  logic                   timer_done,
    output logic                   timer_start,
    output cache_pkg::ctrl_state_t state,
    output logic                   tag_we,
    output logic                   data_we,
    mem_if.client                  mem,
    output logic                   ack
);

    cache_pkg::ctrl_state_t next_state;
    logic                   mem_we_q;
    logic                   store_hit;

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state <= cache_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            cache_pkg::IDLE: begin
                if (cyc && stb) begin
                    next_state = cache_pkg::LOOKUP; // arrays read the index this cycle.
                end
            end
            cache_pkg::LOOKUP: begin
                if (hit) begin
                    next_state = cache_pkg::IDLE;
                end else if (dirty) begin
                    next_state = cache_pkg::WRITE_BACK;
                end else begin
                    next_state = cache_pkg::REFILL;
                end
            end
            cache_pkg::WRITE_BACK: begin
                if (timer_done) begin
                    next_state = cache_pkg::REFILL;
                end
            end
            cache_pkg::REFILL: begin
                if (timer_done) begin
                    next_state = cache_pkg::FILL;
                end
            end
            cache_pkg::FILL: begin
                next_state = cache_pkg::LOOKUP; // retried as a hit.
            end
            default: begin
                next_state = cache_pkg::IDLE;
            end
        endcase
    end

    // every memory wait starts on the way into its state.
    assign timer_start = (next_state != state) &&
                         (next_state == cache_pkg::WRITE_BACK ||
                          next_state == cache_pkg::REFILL);

    // the victim goes out in the first write-back cycle only.
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            mem_we_q <= 1'b0;
        end else begin
            mem_we_q <= (state == cache_pkg::LOOKUP) &&
                        (next_state == cache_pkg::WRITE_BACK);
        end
    end

    assign mem.we = mem_we_q;

    assign store_hit = (state == cache_pkg::LOOKUP) && hit && we;

    assign tag_we  = store_hit || (state == cache_pkg::FILL);
    assign data_we = store_hit || (state == cache_pkg::FILL);

    assign ack = (state == cache_pkg::LOOKUP) && hit;

endmodule

//--- rtl/cache_datapath.sv
`timescale 1ns/10ps

module cache_datapath (
    input  logic                    we,
    input  bus_pkg::wb_addr_t       adr,
    input  bus_pkg::wb_sel_t        sel,
    input  bus_pkg::wb_data_t       dat_w,
    input  cache_pkg::ctrl_state_t  state,
    input  cache_pkg::tag_entry_t   tag_rd,
    input  bus_pkg::wb_data_t       data_rd,
    output cache_pkg::tag_entry_t   tag_wr,
    output bus_pkg::wb_data_t       data_wr,
    output cache_pkg::cache_index_t index,
    output logic                    hit,
    output logic                    dirty,
    output bus_pkg::wb_data_t       dat_r,
    mem_if.client                   mem
);

    localparam int INDEX_W = $bits(cache_pkg::cache_index_t);
    localparam int ADDR_W  = $bits(bus_pkg::wb_addr_t);
    localparam int LANES   = $bits(bus_pkg::wb_sel_t);

    cache_pkg::cache_tag_t req_tag;
    bus_pkg::wb_data_t     merged;
    bus_pkg::wb_data_t     masked;

    assign index   = adr[INDEX_W-1:0];
    assign req_tag = adr[ADDR_W-1:INDEX_W];

    assign hit   = tag_rd.valid && (tag_rd.tag == req_tag);
    assign dirty = tag_rd.valid && tag_rd.dirty;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            merged[8*i +: 8] = sel[i] ? dat_w[8*i +: 8] : data_rd[8*i +: 8];
            masked[8*i +: 8] = sel[i] ? data_rd[8*i +: 8] : 8'h00;
        end
    end

    assign dat_r = masked;

    always_comb begin
        tag_wr.valid = 1'b1;
        tag_wr.tag   = req_tag;
        if (state == cache_pkg::LOOKUP) begin // only a store hit writes here.
            tag_wr.dirty = we;
            data_wr      = merged;
        end else begin // anything else written is a fill.
            tag_wr.dirty = 1'b0;
            data_wr      = mem.rdata;
        end
    end

    // the victim's address is rebuilt from its stored tag.
    assign mem.addr  = (state == cache_pkg::WRITE_BACK) ? {tag_rd.tag, index} : adr;
    assign mem.wdata = data_rd;

endmodule

//--- rtl/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

`define CACHE_ADDR_W      10   // word address width covering all of main memory.
`define CACHE_DATA_W      32
`define CACHE_SEL_W       4    // one select bit per byte lane.
`define CACHE_INDEX_W     4    // index width of the direct-mapped sets.
`define CACHE_SETS        (1 << `CACHE_INDEX_W)
`define CACHE_MEM_WORDS   1024 // backing memory depth in words.
`define CACHE_MEM_LATENCY 4    // cycles from presenting a memory access to its completion.

`endif

//--- rtl/cache_pkg.sv
`include "cache_defs.svh"

package cache_pkg;

    typedef logic [`CACHE_INDEX_W-1:0] cache_index_t;

    // the address bits above the index.
    typedef logic [`CACHE_ADDR_W-`CACHE_INDEX_W-1:0] cache_tag_t;

    typedef struct packed {
        logic       valid;
        logic       dirty;
        cache_tag_t tag;
    } tag_entry_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITE_BACK,
        REFILL,
        FILL
    } ctrl_state_t;

endpackage

//--- rtl/cache_ram.sv
`timescale 1ns/10ps
`include "cache_defs.svh"

module cache_ram #(
    parameter type entry_t = logic [31:0],
    parameter int  DEPTH   = `CACHE_SETS
) (
    input  logic                    clk,
    input  logic                    rst_b,
    input  cache_pkg::cache_index_t index,
    input  logic                    we,
    input  entry_t                  wr_entry,
    output entry_t                  rd_entry
);

    entry_t ram [DEPTH];

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            for (int i = 0; i < DEPTH; i++) begin
                ram[i] <= '0; // tags come up invalid.
            end
            rd_entry <= '0;
        end else begin
            if (we) begin
                ram[index] <= wr_entry;
                rd_entry   <= wr_entry; // write first, so a fill is visible next cycle.
            end else begin
                rd_entry <= ram[index];
            end
        end
    end

endmodule

//--- rtl/dcache_top.sv
`timescale 1ns/10ps
`include "cache_defs.svh"

module dcache_top (
    input  logic              clk,
    input  logic              rst_b,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  bus_pkg::wb_addr_t adr,
    input  bus_pkg::wb_sel_t  sel,
    input  bus_pkg::wb_data_t dat_w,
    output bus_pkg::wb_data_t dat_r,
    output logic              ack
);

    logic                    hit;
    logic                    dirty;
    logic                    timer_start;
    logic                    timer_done;
    logic                    tag_we;
    logic                    data_we;
    cache_pkg::ctrl_state_t  state;
    cache_pkg::cache_index_t index;
    cache_pkg::tag_entry_t   tag_rd;
    cache_pkg::tag_entry_t   tag_wr;
    bus_pkg::wb_data_t       data_rd;
    bus_pkg::wb_data_t       data_wr;

    mem_if i_mem_if ();

    cache_ctrl i_cache_ctrl (
        .clk(clk), .rst_b(rst_b), .cyc(cyc), .stb(stb), .we(we),
        .hit(hit), .dirty(dirty), .timer_done(timer_done), .timer_start(timer_start),
        .state(state), .tag_we(tag_we), .data_we(data_we), .mem(i_mem_if), .ack(ack)
    );

    mem_latency_timer i_mem_latency_timer (
        .clk(clk), .rst_b(rst_b), .start(timer_start), .done(timer_done)
    );

    cache_datapath i_cache_datapath (
        .we(we), .adr(adr), .sel(sel), .dat_w(dat_w), .state(state),
        .tag_rd(tag_rd), .data_rd(data_rd), .tag_wr(tag_wr), .data_wr(data_wr),
        .index(index), .hit(hit), .dirty(dirty), .dat_r(dat_r), .mem(i_mem_if)
    );

    cache_ram #(.entry_t(cache_pkg::tag_entry_t), .DEPTH(`CACHE_SETS)) i_tag_ram (
        .clk(clk), .rst_b(rst_b), .index(index), .we(tag_we),
        .wr_entry(tag_wr), .rd_entry(tag_rd)
    );

    cache_ram #(.entry_t(bus_pkg::wb_data_t), .DEPTH(`CACHE_SETS)) i_data_ram (
        .clk(clk), .rst_b(rst_b), .index(index), .we(data_we),
        .wr_entry(data_wr), .rd_entry(data_rd)
    );

    main_mem i_main_mem (
        .clk(clk), .mem(i_mem_if)
    );

endmodule

//--- rtl/main_mem.sv
`timescale 1ns/10ps
`include "cache_defs.svh"

module main_mem (
    input  logic  clk,
    mem_if.memory mem
);

    bus_pkg::wb_data_t ram [`CACHE_MEM_WORDS];
    bus_pkg::wb_data_t rdata_q;

    initial begin
        for (int i = 0; i < `CACHE_MEM_WORDS; i++) begin
            ram[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (mem.we) begin
            ram[mem.addr] <= mem.wdata;
        end
    end

    // read data follows the address one cycle later.
    always_ff @(posedge clk) begin
        rdata_q <= ram[mem.addr];
    end

    assign mem.rdata = rdata_q;

endmodule

//--- rtl/mem_if.sv
`timescale 1ns/10ps

interface mem_if;

    bus_pkg::wb_addr_t addr;
    bus_pkg::wb_data_t wdata;
    bus_pkg::wb_data_t rdata;
    logic              we;

    modport client ( // the controller drives we and the datapath the rest.
        output addr,
        output wdata,
        output we,
        input  rdata
    );

    modport memory (
        input  addr,
        input  wdata,
        input  we,
        output rdata
    );

endinterface

//--- rtl/mem_latency_timer.sv
`timescale 1ns/10ps
`include "cache_defs.svh"

module mem_latency_timer (
    input  logic clk,
    input  logic rst_b,
    input  logic start,
    output logic done
);

    localparam int CNT_W = $clog2(`CACHE_MEM_LATENCY + 1);

    logic [CNT_W-1:0] count;

    // the count holds the cycles left, including the current one.
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            count <= '0;
        end else if (start) begin
            count <= CNT_W'(`CACHE_MEM_LATENCY);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign done = (count == CNT_W'(1)); // high in the last cycle of the wait.

endmodule
